//--- verilog/par_consts.svh
`ifndef PAR_CONSTS_SVH
`define PAR_CONSTS_SVH

// Worker count
`define N_CORE 4

// Datapath widths
`define GC_WIDTH 16
`define GD_WIDTH 16
`define SUM_WIDTH 32
`define CNT_WIDTH 16

// APB bus widths
`define APB_AW 8
`define APB_DW 32

`endif

//--- verilog/par_pkg.sv
`include "par_consts.svh"

package par_pkg;

	// Loop index, wraps at GC_WIDTH
	typedef logic [`GC_WIDTH-1:0] gc_t;
	typedef logic signed [`GD_WIDTH-1:0] gd_t;
	typedef logic [`CNT_WIDTH-1:0] cnt_t;
	// Sum of squares, modulo 2^SUM_WIDTH
	typedef logic [`SUM_WIDTH-1:0] sum_t;

	typedef enum logic [`APB_AW-1:0] {
		REG_BASE   = 8'h00,
		REG_STRIDE = 8'h04,
		REG_COUNT  = 8'h08,
		REG_CTRL   = 8'h0C,
		REG_RESULT = 8'h10
	} reg_addr_e;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [`APB_AW-1:0] paddr;
		logic [`APB_DW-1:0] pwdata;
	} apb_req_t;

	// Fork to the dispenser, issue is a one-cycle pulse
	typedef struct packed {
		logic issue;
		gc_t base;
		gd_t stride;
		cnt_t count;
	} fork_t;

	typedef enum logic [1:0] {CORE_IDLE, CORE_RUN, CORE_DRAIN} core_state_e;
	typedef enum logic [1:0] {JOB_IDLE, JOB_BUSY, JOB_DONE} job_state_e;

endpackage

//--- verilog/apb_ctrl.sv
`timescale 1ns/1ns
`include "par_consts.svh"

module apb_ctrl (
	input logic clk,
	input logic rst,
	input par_pkg::apb_req_t apb,
	output logic [`APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output par_pkg::fork_t job,
	output logic busy,
	input par_pkg::sum_t result,
	input logic result_valid
);
	import par_pkg::*;

	job_state_e state;
	gc_t base_r;
	gd_t stride_r;
	cnt_t count_r;
	sum_t result_r;
	logic issue_q;
	logic access;
	logic addr_ok;
	logic wr_ok;
	logic start;

	assign access = apb.psel && apb.penable;

	always_comb begin
		case (apb.paddr)
			REG_BASE, REG_STRIDE, REG_COUNT, REG_CTRL, REG_RESULT: addr_ok = 1'b1;
			default: addr_ok = 1'b0;
		endcase
	end

	// No wait states
	assign pready = 1'b1;
	assign pslverr = access && !addr_ok;

	// Job registers are frozen while a job runs
	assign wr_ok = access && apb.pwrite && (state != JOB_BUSY);
	assign start = wr_ok && (apb.paddr == REG_CTRL) && apb.pwdata[0];
	assign busy = (state == JOB_BUSY);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= JOB_IDLE;
			issue_q <= 1'b0;
			base_r <= '0;
			stride_r <= '0;
			count_r <= '0;
		end else begin
			issue_q <= start;
			if (wr_ok && apb.paddr == REG_BASE) base_r <= apb.pwdata[`GC_WIDTH-1:0];
			if (wr_ok && apb.paddr == REG_STRIDE) stride_r <= apb.pwdata[`GD_WIDTH-1:0];
			if (wr_ok && apb.paddr == REG_COUNT) count_r <= apb.pwdata[`CNT_WIDTH-1:0];
			if (start) begin
				state <= JOB_BUSY;
			end else if (state == JOB_BUSY && result_valid) begin
				state <= JOB_DONE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (result_valid) begin
			result_r <= result;
		end
	end

	assign job.issue = issue_q;
	assign job.base = base_r;
	assign job.stride = stride_r;
	assign job.count = count_r;

	// Stride reads back sign extended
	always_comb begin
		case (apb.paddr)
			REG_BASE: prdata = `APB_DW'(base_r);
			REG_STRIDE: prdata = `APB_DW'(stride_r);
			REG_COUNT: prdata = `APB_DW'(count_r);
			REG_CTRL: prdata = {30'b0, state == JOB_DONE, busy};
			REG_RESULT: prdata = `APB_DW'(result_r);
			default: prdata = '0;
		endcase
	end

endmodule

//--- verilog/index_dispenser.sv
`timescale 1ns/1ns
`include "par_consts.svh"

module index_dispenser (
	input logic clk,
	input logic rst,
	input par_pkg::fork_t job,
	input logic [`N_CORE-1:0] req,
	output logic [`N_CORE-1:0] grant,
	output par_pkg::gc_t index [`N_CORE],
	output logic drained
);
	import par_pkg::*;

	gc_t gc;
	gd_t gd;
	cnt_t remaining;
	cnt_t n_grant;

	// Each requester gets gc + rank * gd, rank counts lower requesters
	always_comb begin
		cnt_t rank;
		rank = '0;
		n_grant = '0;
		for (int i = 0; i < `N_CORE; i++) begin
			grant[i] = req[i] && (rank < remaining);
			index[i] = gc + gd * rank;
			if (grant[i]) begin
				n_grant = n_grant + cnt_t'(1);
			end
			if (req[i]) begin
				rank = rank + cnt_t'(1);
			end
		end
	end

	assign drained = (remaining == '0);

	// Remaining count is the only control state here
	always_ff @(posedge clk) begin
		if (rst) begin
			remaining <= '0;
		end else if (job.issue) begin
			remaining <= job.count;
		end else begin
			remaining <= remaining - n_grant;
		end
	end

	// Global counter and stride
	always_ff @(posedge clk) begin
		if (job.issue) begin
			gc <= job.base;
			gd <= job.stride;
		end else begin
			gc <= gc + gd * n_grant;
		end
	end

endmodule

//--- verilog/loop_core.sv
`timescale 1ns/1ns
`include "par_consts.svh"

module loop_core #(
	parameter int CORE_I = 0
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic grant,
	input par_pkg::gc_t index,
	input logic drained,
	output logic req,
	output par_pkg::sum_t partial,
	output logic ending
);
	import par_pkg::*;

	// Nonzero seed, differs per core
	localparam logic [7:0] SEED = 8'(8'h5b + CORE_I * 29) | 8'h01;

	core_state_e state;
	logic [7:0] lfsr;
	logic lfsr_fb;
	logic s1_valid;
	sum_t sq;

	// x^8 + x^6 + x^5 + x^4 + 1
	assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr <= SEED;
		end else begin
			lfsr <= {lfsr[6:0], lfsr_fb};
		end
	end

	assign req = (state == CORE_RUN) && lfsr[0];
	// Nothing left to hand out and no square waiting for the accumulator
	assign ending = drained && !s1_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= CORE_IDLE;
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= grant;
			case (state)
				CORE_IDLE: if (start) state <= CORE_RUN;
				CORE_RUN: if (drained) state <= CORE_DRAIN;
				CORE_DRAIN: state <= CORE_IDLE;
				default: state <= CORE_IDLE;
			endcase
		end
	end

	// Stage one squares, stage two accumulates
	always_ff @(posedge clk) begin
		sq <= sum_t'(index) * sum_t'(index);
		if (start) begin
			partial <= '0;
		end else if (s1_valid) begin
			partial <= partial + sq;
		end
	end

endmodule

//--- verilog/sum_reducer.sv
`timescale 1ns/1ns
`include "par_consts.svh"

module sum_reducer (
	input logic clk,
	input logic rst,
	input par_pkg::sum_t partial [`N_CORE],
	input logic [`N_CORE-1:0] ending,
	input logic busy,
	output par_pkg::sum_t result,
	output logic result_valid
);
	import par_pkg::*;

	logic busy_q;
	logic armed;
	logic all_end;
	sum_t total;

	assign all_end = armed && (&ending);

	always_comb begin
		total = '0;
		for (int i = 0; i < `N_CORE; i++) begin
			total = total + partial[i];
		end
	end

	// Arm on the rising edge of busy, fire once
	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			armed <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			busy_q <= busy;
			result_valid <= all_end;
			if (busy && !busy_q) begin
				armed <= 1'b1;
			end else if (all_end) begin
				armed <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (all_end) begin
			result <= total;
		end
	end

endmodule

//--- verilog/par_top.sv
`timescale 1ns/1ns
`include "par_consts.svh"

module par_top (
	input logic clk,
	input logic rst,
	input par_pkg::apb_req_t apb,
	output logic [`APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	import par_pkg::*;

	fork_t job;
	logic busy;
	logic [`N_CORE-1:0] req;
	logic [`N_CORE-1:0] grant;
	gc_t index [`N_CORE];
	logic drained;
	sum_t partial [`N_CORE];
	logic [`N_CORE-1:0] ending;
	sum_t result;
	logic result_valid;

	apb_ctrl ctrl_i (
		.clk,
		.rst,
		.apb,
		.prdata,
		.pready,
		.pslverr,
		.job,
		.busy,
		.result,
		.result_valid
	);

	index_dispenser disp_i (
		.clk,
		.rst,
		.job,
		.req,
		.grant,
		.index,
		.drained
	);

	// Workers run side by side, started by the fork pulse
	for (genvar i = 0; i < `N_CORE; i++) begin : g_core
		loop_core #(
			.CORE_I(i)
		) core_i (
			.clk,
			.rst,
			.start(job.issue),
			.grant(grant[i]),
			.index(index[i]),
			.drained,
			.req(req[i]),
			.partial(partial[i]),
			.ending(ending[i])
		);
	end

	sum_reducer red_i (
		.clk,
		.rst,
		.partial,
		.ending,
		.busy,
		.result,
		.result_valid
	);

endmodule

//--- sim/par_tb.sv
`timescale 1ns/1ns

module par_tb;
	import par_pkg::*;

	localparam int N_ROW = 10;
	// Row that also gets writes while its job runs
	localparam int POKE_ROW = 3;

	logic clk;
	logic rst;
	apb_req_t apb;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	logic [15:0] row_base [N_ROW];
	logic [15:0] row_stride [N_ROW];
	int row_count [N_ROW];
	logic [31:0] row_exp [N_ROW];

	int seed = 44;
	int n_checks = 0;
	int n_errors = 0;
	int cycles = 0;
	int cycle_limit = 1000;

	par_top dut_i (
		.clk,
		.rst,
		.apb,
		.prdata,
		.pready,
		.pslverr
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// Sum of squares of base + k*stride, indices wrap at 16 bits
	function automatic logic [31:0] sum_squares(input logic [15:0] base,
			input logic [15:0] stride, input int count);
		logic [15:0] idx;
		logic [31:0] acc;
		idx = base;
		acc = '0;
		for (int k = 0; k < count; k++) begin
			acc = acc + {16'b0, idx} * {16'b0, idx};
			idx = idx + stride;
		end
		return acc;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// Setup phase, then access phase sampled mid-cycle
	task automatic apb_access(input logic write, input logic [7:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, input logic exp_err);
		@(posedge clk);
		#2;
		apb.psel = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite = write;
		apb.paddr = addr;
		apb.pwdata = wdata;
		@(posedge clk);
		#2;
		apb.penable = 1'b1;
		#8;
		rdata = prdata;
		check("pready", 32'd1, {31'b0, pready});
		check("pslverr", {31'b0, exp_err}, {31'b0, pslverr});
		@(posedge clk);
		#2;
		apb.psel = 1'b0;
		apb.penable = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		apb_access(1'b1, addr, data, unused, 1'b0);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		apb_access(1'b0, addr, 32'b0, data, 1'b0);
	endtask

	task automatic wait_done();
		logic [31:0] ctrl;
		ctrl = '0;
		while (!ctrl[1]) begin
			apb_read(REG_CTRL, ctrl);
		end
		// Done set and busy cleared together
		check("ctrl", 32'd2, ctrl);
	endtask

	task automatic set_row(input int r, input logic [15:0] base, input logic [15:0] stride,
			input int count);
		row_base[r] = base;
		row_stride[r] = stride;
		row_count[r] = count;
		row_exp[r] = sum_squares(base, stride, count);
	endtask

	task automatic fill_table();
		set_row(0, 16'd5, 16'd1, 1);
		set_row(1, 16'd7, 16'd3, 0);
		set_row(2, 16'd0, 16'd1, 10);
		set_row(3, 16'd100, 16'd7, 60);
		set_row(4, 16'd1000, 16'd2, 5);
		// Stride -3 walks through zero and wraps
		set_row(5, 16'd20, 16'hfffd, 17);
		set_row(6, 16'hfff0, 16'd5, 12);
		for (int r = 7; r < N_ROW; r++) begin
			set_row(r, 16'($random(seed)), 16'($random(seed)), ($random(seed) & 63) + 1);
		end
	endtask

	task automatic run_row(input int r);
		logic [31:0] rd;
		int errors_before;
		errors_before = n_errors;
		apb_write(REG_BASE, {16'b0, row_base[r]});
		apb_write(REG_STRIDE, {{16{row_stride[r][15]}}, row_stride[r]});
		apb_write(REG_COUNT, 32'(row_count[r]));
		apb_read(REG_BASE, rd);
		check("base", {16'b0, row_base[r]}, rd);
		apb_read(REG_STRIDE, rd);
		check("stride", {{16{row_stride[r][15]}}, row_stride[r]}, rd);
		apb_read(REG_COUNT, rd);
		check("count", 32'(row_count[r]), rd);
		apb_write(REG_CTRL, 32'd1);
		// Busy set, done from the previous job cleared
		apb_read(REG_CTRL, rd);
		check("ctrl", 32'd1, rd);
		if (r == POKE_ROW) begin
			apb_write(REG_BASE, 32'h1234);
			apb_write(REG_CTRL, 32'd1);
		end
		wait_done();
		apb_read(REG_RESULT, rd);
		check("result", row_exp[r], rd);
		if (r == POKE_ROW) begin
			apb_read(REG_BASE, rd);
			check("base", {16'b0, row_base[r]}, rd);
		end
		$display("test %0d: base %h stride %h count %0d result %h %s", r, row_base[r],
			row_stride[r], row_count[r], row_exp[r], (n_errors == errors_before) ? "ok" : "fail");
	endtask

	initial begin
		logic [31:0] rd;
		int total;
		int errors_before;
		apb = '0;
		rst = 1'b1;
		fill_table();
		total = 0;
		for (int r = 0; r < N_ROW; r++) begin
			total += row_count[r];
		end
		cycle_limit = 200 * total + 1000;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;

		errors_before = n_errors;
		apb_read(REG_CTRL, rd);
		check("ctrl", 32'd0, rd);
		apb_access(1'b0, 8'h14, 32'b0, rd, 1'b1);
		apb_access(1'b1, 8'h20, 32'd1, rd, 1'b1);
		apb_read(REG_CTRL, rd);
		check("ctrl", 32'd0, rd);
		$display("test reset and unmapped access: %s", (n_errors == errors_before) ? "ok" : "fail");

		for (int r = 0; r < N_ROW; r++) begin
			run_row(r);
		end

		$display("checks %0d, errors %0d, rows %0d", n_checks, n_errors, N_ROW);
		if (n_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- sim.f
+incdir+verilog
verilog/par_pkg.sv
verilog/apb_ctrl.sv
verilog/index_dispenser.sv
verilog/loop_core.sv
verilog/sum_reducer.sv
verilog/par_top.sv
sim/par_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= par_tb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing
PASS_MSG ?= ALL CHECKS PASSED

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard verilog/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
